/* vlog.f */
rsPkg.sv
issueAllocator.sv
stationEntry.sv
dispatchArbiter.sv
dpStation.sv
dpStation_sva.sv
tbDpStation.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbDpStation
RTL_TOP   ?= dpStation
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^\*\*\* TEST PASSED \*\*\*$$' $(LOG) || \
		(echo "Simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) rsPkg.sv issueAllocator.sv stationEntry.sv \
		dispatchArbiter.sv dpStation.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tbDpStation.sv */
`default_nettype none

module tbDpStation;
    import rsPkg::*;

    localparam int NumEntries    = 4;
    localparam int NumTags       = 1 << RobTagWidth;
    localparam int RandomIssues  = 300;
    localparam int TimeoutCycles = (RandomIssues + 8 * NumEntries + 100) * 16;

    logic     CLK;
    logic     Reset;
    logic     Issue;
    issueReqT IssueReq;
    logic     IssueCredit;
    cdbT      Cdb;
    logic     ExecValid;
    execReqT  ExecReq;

    // Tag use is 0 free, 1 station instruction, 2 outside producer.
    int          tagUse     [NumTags];
    bit          dispatched [NumTags];
    bit          knownA     [NumTags];
    bit          knownB     [NumTags];
    logic [31:0] expA       [NumTags];
    logic [31:0] expB       [NumTags];
    int          waitA      [NumTags];
    int          waitB      [NumTags];
    aluOpT       opOf       [NumTags];
    int          dueCycle   [NumTags];
    logic [31:0] prodValue  [NumTags];

    int          credits;
    bit          creditDue;
    int          cycleNum;
    int          errors;
    int          testStartErrors;
    int          testsRun;
    int          testsFailed;
    int          issuedCount;
    int          dispatchCount;
    int          returnedCount;
    int          bcastTag;
    int          lastIssueTag;
    int          checkTag;
    int          checkCycle;
    bit          holdProducers;
    logic [31:0] rngState;

    dpStation #(
        .NumEntries(NumEntries)
    ) u_dpStation (
        .CLK         (CLK),
        .Reset       (Reset),
        .Issue       (Issue),
        .IssueReq    (IssueReq),
        .IssueCredit (IssueCredit),
        .Cdb         (Cdb),
        .ExecValid   (ExecValid),
        .ExecReq     (ExecReq)
    );

    always #20 CLK = ~CLK;

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] aluResult(input aluOpT op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            Add:     return a + b;
            Sub:     return a - b;
            And:     return a & b;
            Orr:     return a | b;
            Eor:     return a ^ b;
            default: return b;  // Mov.
        endcase
    endfunction

    function automatic int findFreeTag();
        int start;
        int t;
        start = int'(nextRandom() % NumTags);
        for (int k = 0; k < NumTags; k++) begin
            t = (start + k) % NumTags;
            if (tagUse[t] == 0) return t;
        end
        return -1;
    endfunction

    function automatic bit anyTagBusy();
        for (int t = 0; t < NumTags; t++) begin
            if (tagUse[t] != 0) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Reuse a live producer half the time, otherwise start a new one.
    function automatic int pickProducer();
        int          t;
        logic [31:0] r;
        r = nextRandom();
        if (r[0]) begin
            for (int k = 0; k < NumTags; k++) begin
                if (tagUse[k] == 2 && k != bcastTag) return k;
            end
        end
        t = findFreeTag();
        if (t >= 0) begin
            tagUse[t]    = 2;
            prodValue[t] = nextRandom();
            dueCycle[t]  = cycleNum + 2 + int'(nextRandom() % 32'd8);
        end
        return t;
    endfunction

    task automatic checkOutputs();
        int t;
        assert (IssueCredit == creditDue) else begin
            $display("** Error: IssueCredit got %h expected %h", IssueCredit, creditDue);
            errors++;
        end
        if (IssueCredit) begin
            credits++;
            returnedCount++;
        end
        creditDue = 1'b0;
        if (ExecValid) begin
            t = int'(ExecReq.dest);
            assert (tagUse[t] == 1 && !dispatched[t]) else begin
                $display("Tag %0d dispatched while not waiting in the station", t);
                errors++;
            end
            if (tagUse[t] == 1 && !dispatched[t]) begin
                assert (knownA[t] && knownB[t]) else begin
                    $display("Tag %0d dispatched before its producer broadcast", t);
                    errors++;
                end
                assert (ExecReq.srcA == expA[t]) else begin
                    $display("** Error: ExecReq.srcA got %h expected %h", ExecReq.srcA, expA[t]);
                    errors++;
                end
                assert (ExecReq.srcB == expB[t]) else begin
                    $display("** Error: ExecReq.srcB got %h expected %h", ExecReq.srcB, expB[t]);
                    errors++;
                end
                assert (ExecReq.op == opOf[t]) else begin
                    $display("** Error: ExecReq.op got %h expected %h", ExecReq.op, opOf[t]);
                    errors++;
                end
                if (t == checkTag) begin
                    assert (cycleNum == checkCycle) else begin
                        $display("Bypassed tag %0d dispatched on the wrong cycle", t);
                        errors++;
                    end
                    checkTag = -1;
                end
                dispatched[t] = 1'b1;
                dispatchCount++;
                dueCycle[t] = cycleNum + 1 + int'(nextRandom() % 32'd4);
            end
        end
    endtask

    // One CDB result per cycle, and wake-up of the model's waiters.
    task automatic chooseBroadcast(output cdbT bus);
        int start;
        int t;
        bus = '0;
        start = int'(nextRandom() % NumTags);
        for (int k = 0; k < NumTags && !bus.valid; k++) begin
            t = (start + k) % NumTags;
            if (tagUse[t] == 1 && dispatched[t] && dueCycle[t] <= cycleNum) begin
                bus.value = aluResult(opOf[t], expA[t], expB[t]);
                creditDue = 1'b1;
            end else if (tagUse[t] == 2 && !holdProducers && dueCycle[t] <= cycleNum) begin
                bus.value = prodValue[t];
            end else begin
                continue;
            end
            bus.valid = 1'b1;
            bus.tag   = RobTagWidth'(t);
            bcastTag  = t;
        end
        if (bus.valid) begin
            for (int s = 0; s < NumTags; s++) begin
                if (tagUse[s] == 1 && !knownA[s] && waitA[s] == bcastTag) begin
                    knownA[s] = 1'b1;
                    expA[s]   = bus.value;
                end
                if (tagUse[s] == 1 && !knownB[s] && waitB[s] == bcastTag) begin
                    knownB[s] = 1'b1;
                    expB[s]   = bus.value;
                end
            end
        end
    endtask

    // Source kinds are 0 register, 1 pending, 2 bypass, 3 ROB forward, 4 immediate.
    task automatic makeSource(input int kindIn, input int dest, input bit isB, input cdbT bus,
                              inout issueReqT req);
        int          kind;
        int          p;
        bit          known;
        logic [31:0] value;
        logic [31:0] r;
        srcLookupT   src;
        logic        immSel;
        logic [31:0] imm;
        kind         = kindIn;
        p            = -1;
        known        = 1'b1;
        value        = '0;
        src.busy     = 1'b1;
        src.tag      = RobTagWidth'(nextRandom());
        r            = nextRandom();
        src.fwdValid = r[3];
        src.fwdData  = nextRandom();
        src.rfData   = nextRandom();
        immSel       = 1'b0;
        imm          = nextRandom();
        if (kind == 4 && !isB) kind = 0;
        if (kind == 2 && !bus.valid) kind = 0;
        if (kind == 1) begin
            p = pickProducer();
            if (p < 0) kind = 0;
        end
        case (kind)
            0: begin
                src.busy = 1'b0;
                value    = src.rfData;
            end
            1: begin
                src.tag      = RobTagWidth'(p);
                src.fwdValid = 1'b0;
                known        = 1'b0;
            end
            2: begin
                src.tag = bus.tag;
                value   = bus.value;
            end
            3: begin
                if (bus.valid && src.tag == bus.tag) src.tag = src.tag ^ 1'b1;
                src.fwdValid = 1'b1;
                value        = src.fwdData;
            end
            default: begin
                immSel = 1'b1;
                value  = imm;
            end
        endcase
        if (isB) begin
            req.srcB     = src;
            req.immSel   = immSel;
            req.imm      = imm;
            knownB[dest] = known;
            expB[dest]   = value;
            waitB[dest]  = p;
        end else begin
            req.srcA     = src;
            knownA[dest] = known;
            expA[dest]   = value;
            waitA[dest]  = p;
        end
    endtask

    task automatic step(input bit wantIssue, input int kindA, input int kindB);
        cdbT      bus;
        issueReqT req;
        int       dest;
        logic     doIssue;
        @(posedge CLK);
        #2;
        cycleNum++;
        checkOutputs();
        bcastTag = -1;
        chooseBroadcast(bus);
        req     = '0;
        doIssue = 1'b0;
        dest    = (wantIssue && credits > 0) ? findFreeTag() : -1;
        if (dest >= 0) begin
            tagUse[dest]     = 1;
            dispatched[dest] = 1'b0;
            opOf[dest]       = aluOpT'(5'(nextRandom() % 32'd6));
            makeSource((kindA < 0) ? int'(nextRandom() % 32'd5) : kindA, dest, 1'b0, bus,
                       req);
            makeSource((kindB < 0) ? int'(nextRandom() % 32'd5) : kindB, dest, 1'b1, bus,
                       req);
            req.op       = opOf[dest];
            req.dest     = RobTagWidth'(dest);
            doIssue      = 1'b1;
            lastIssueTag = dest;
            credits--;
            issuedCount++;
        end
        if (bcastTag >= 0) tagUse[bcastTag] = 0;  // Retired after the issue pick.
        Issue    = doIssue;
        IssueReq = req;
        Cdb      = bus;
    endtask

    task automatic drain();
        while (anyTagBusy() || creditDue) begin
            step(1'b0, 0, 0);
        end
        step(1'b0, 0, 0);
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errors != testStartErrors) testsFailed++;
        $display("%s: %0d errors", name, errors - testStartErrors);
        testStartErrors = errors;
    endtask

    task automatic checkBalance();
        assert (credits == NumEntries && returnedCount == issuedCount) else begin
            $display("Credits not all returned, %0d held, %0d returned of %0d issued",
                     credits, returnedCount, issuedCount);
            errors++;
        end
        assert (dispatchCount == issuedCount) else begin
            $display("Dispatched %0d of %0d issued", dispatchCount, issuedCount);
            errors++;
        end
    endtask

    initial begin
        #(TimeoutCycles * 40);
        $display("Watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int p;
        CLK = 1'b0;
        Reset = 1'b1;
        Issue = 1'b0;
        IssueReq = '0;
        Cdb = '0;
        rngState = 32'h2dea;
        credits = NumEntries;
        creditDue = 1'b0;
        cycleNum = 0;
        errors = 0;
        testStartErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        issuedCount = 0;
        dispatchCount = 0;
        returnedCount = 0;
        bcastTag = -1;
        lastIssueTag = -1;
        checkTag = -1;
        checkCycle = 0;
        holdProducers = 1'b0;
        for (int t = 0; t < NumTags; t++) begin
            tagUse[t] = 0;
        end
        repeat (4) @(posedge CLK);
        #2;
        Reset = 1'b0;

        // Fill the station with ops stuck on silent producers.
        holdProducers = 1'b1;
        for (int i = 0; i < NumEntries; i++) begin
            step(1'b1, 1, 4);
        end
        repeat (8) step(1'b1, 0, 0);
        assert (credits == 0 && dispatchCount == 0) else begin
            $display("Full station still had credits or dispatched, credits %0d", credits);
            errors++;
        end
        finishTest("creditsAfterReset");

        holdProducers = 1'b0;  // Wake-up and credit return.
        drain();
        checkBalance();
        finishTest("wakeUpAndCreditReturn");

        p = findFreeTag();
        tagUse[p]    = 2;
        prodValue[p] = nextRandom();
        dueCycle[p]  = cycleNum;
        step(1'b1, 2, 2);
        checkTag   = lastIssueTag;
        checkCycle = cycleNum + 2;
        drain();
        assert (checkTag == -1) else begin
            $display("Bypassed instruction was never checked at dispatch");
            errors++;
        end
        checkBalance();
        finishTest("issueCycleBypass");

        for (int i = 0; i < RandomIssues; i++) begin
            step((nextRandom() % 32'd4) != 32'd0, -1, -1);
        end
        drain();
        checkBalance();
        finishTest("randomRun");

        $display("%0d tests, %0d failed, %0d errors, %0d issued, %0d dispatched",
                 testsRun, testsFailed, errors, issuedCount, dispatchCount);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dpStation_sva.sv */
`default_nettype none

module dpStationSva #(
    parameter int NumEntries = 4
) (
    input wire logic           CLK,
    input wire logic           Reset,
    input wire logic           Issue,
    input wire logic           IssueCredit,
    input wire logic           ExecValid,
    input wire rsPkg::execReqT ExecReq
);
    import rsPkg::*;

    int creditCount;

    // Issuer credits as seen from the station ports.
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            creditCount <= NumEntries;
        end else begin
            creditCount <= creditCount - (Issue ? 1 : 0) + (IssueCredit ? 1 : 0);
        end
    end

    quietInReset: assert property (@(posedge CLK) Reset |-> (!ExecValid && !IssueCredit))
        else $error("ExecValid or IssueCredit active during reset");

    // A credit pulse can be spent in its own cycle.
    issueNeedsCredit: assert property (@(posedge CLK) disable iff (Reset)
        Issue |-> ((creditCount + (IssueCredit ? 1 : 0)) > 0))
        else $error("Issue asserted with no credit left");

    execReqKnown: assert property (@(posedge CLK) disable iff (Reset)
        ExecValid |-> !$isunknown(ExecReq))
        else $error("ExecReq unknown while ExecValid is high");

endmodule

bind dpStation dpStationSva #(
    .NumEntries(NumEntries)
) u_dpStationSva (
    .CLK         (CLK),
    .Reset       (Reset),
    .Issue       (Issue),
    .IssueCredit (IssueCredit),
    .ExecValid   (ExecValid),
    .ExecReq     (ExecReq)
);

`default_nettype wire

/* dpStation.sv */
`default_nettype none

module dpStation #(
    parameter int NumEntries = 4
) (
    input  wire logic            CLK,
    input  wire logic            Reset,
    input  wire logic            Issue,
    input  wire rsPkg::issueReqT IssueReq,
    output logic                 IssueCredit,
    input  wire rsPkg::cdbT      Cdb,
    output logic                 ExecValid,
    output rsPkg::execReqT       ExecReq
);
    import rsPkg::*;

    logic [NumEntries-1:0] writeEn;
    logic [NumEntries-1:0] freeMask;
    logic [NumEntries-1:0] readyMask;
    logic [NumEntries-1:0] releasedMask;
    logic [NumEntries-1:0] grant;
    entryT                 newEntry;
    entryT                 payloads [NumEntries];

    issueAllocator #(
        .NumEntries(NumEntries)
    ) u_issueAllocator (
        .Issue    (Issue),
        .IssueReq (IssueReq),
        .Cdb      (Cdb),
        .FreeMask (freeMask),
        .WriteEn  (writeEn),
        .NewEntry (newEntry)
    );

    // All entries share the resolved payload; only the strobed one takes it.
    for (genvar i = 0; i < NumEntries; i++) begin : gEntry
        stationEntry u_stationEntry (
            .CLK      (CLK),
            .Reset    (Reset),
            .Write    (writeEn[i]),
            .NewEntry (newEntry),
            .Cdb      (Cdb),
            .Grant    (grant[i]),
            .Free     (freeMask[i]),
            .Ready    (readyMask[i]),
            .Payload  (payloads[i]),
            .Released (releasedMask[i])
        );
    end

    dispatchArbiter #(
        .NumEntries(NumEntries)
    ) u_dispatchArbiter (
        .CLK          (CLK),
        .Reset        (Reset),
        .ReadyMask    (readyMask),
        .Payloads     (payloads),
        .ReleasedMask (releasedMask),
        .Grant        (grant),
        .ExecValid    (ExecValid),
        .ExecReq      (ExecReq),
        .IssueCredit  (IssueCredit)
    );

endmodule

`default_nettype wire

/* dispatchArbiter.sv */
`default_nettype none

module dispatchArbiter #(
    parameter int NumEntries = 4
) (
    input  wire logic                  CLK,
    input  wire logic                  Reset,
    input  wire logic [NumEntries-1:0] ReadyMask,
    input  wire rsPkg::entryT          Payloads [NumEntries],
    input  wire logic [NumEntries-1:0] ReleasedMask,
    output logic [NumEntries-1:0]      Grant,
    output logic                       ExecValid,
    output rsPkg::execReqT             ExecReq,
    output logic                       IssueCredit
);
    localparam int IdxWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1;

    logic [IdxWidth-1:0] grantIdx;
    logic                anyReady;

    assign anyReady = |ReadyMask;

    // Scan from the top so the lowest ready index is left standing.
    always_comb begin
        Grant    = '0;
        grantIdx = '0;
        for (int i = NumEntries - 1; i >= 0; i--) begin
            if (ReadyMask[i]) begin
                Grant    = '0;
                Grant[i] = 1'b1;
                grantIdx = IdxWidth'(i);
            end
        end
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            ExecValid   <= 1'b0;
            IssueCredit <= 1'b0;
        end else begin
            ExecValid   <= anyReady;
            IssueCredit <= |ReleasedMask;  // At most one release per cycle.
        end
    end

    always_ff @(posedge CLK) begin
        if (anyReady) begin
            ExecReq.op   <= Payloads[grantIdx].op;
            ExecReq.dest <= Payloads[grantIdx].dest;
            ExecReq.srcA <= Payloads[grantIdx].opA.value;
            ExecReq.srcB <= Payloads[grantIdx].opB.value;
        end
    end

endmodule

`default_nettype wire

/* stationEntry.sv */
`default_nettype none

module stationEntry (
    input  wire logic         CLK,
    input  wire logic         Reset,
    input  wire logic         Write,
    input  wire rsPkg::entryT NewEntry,
    input  wire rsPkg::cdbT   Cdb,
    input  wire logic         Grant,
    output logic              Free,
    output logic              Ready,
    output rsPkg::entryT      Payload,
    output logic              Released
);
    import rsPkg::*;

    entryStateT state;
    logic       busy;
    logic       hitA;
    logic       hitB;

    function automatic logic tagHit(input operandT opnd, input cdbT bus);
        return opnd.pending && bus.valid && (bus.tag == opnd.tag);
    endfunction

    assign busy  = (state != rsPkg::Free);
    assign Free  = !busy;
    assign Ready = (state == Waiting) && !Payload.opA.pending && !Payload.opB.pending;

    // Own result on the CDB, so the ROB has it.
    assign Released = busy && Cdb.valid && (Cdb.tag == Payload.dest);

    assign hitA = (state == Waiting) && tagHit(Payload.opA, Cdb);
    assign hitB = (state == Waiting) && tagHit(Payload.opB, Cdb);

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state <= rsPkg::Free;
        end else if (Released) begin
            state <= rsPkg::Free;
        end else begin
            case (state)
                rsPkg::Free: begin
                    if (Write) begin
                        state <= Waiting;
                    end
                end
                Waiting: begin
                    if (Grant) begin
                        state <= Dispatched;
                    end
                end
                Dispatched: begin
                    state <= Dispatched;  // Held until release.
                end
                default: begin
                    state <= rsPkg::Free;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (Write && !busy) begin
            Payload <= NewEntry;
        end else begin
            if (hitA) begin
                Payload.opA.pending <= 1'b0;
                Payload.opA.value   <= Cdb.value;
            end
            if (hitB) begin
                Payload.opB.pending <= 1'b0;
                Payload.opB.value   <= Cdb.value;
            end
        end
    end

endmodule

`default_nettype wire

/* issueAllocator.sv */
`default_nettype none

module issueAllocator #(
    parameter int NumEntries = 4
) (
    input  wire logic                  Issue,
    input  wire rsPkg::issueReqT       IssueReq,
    input  wire rsPkg::cdbT            Cdb,
    input  wire logic [NumEntries-1:0] FreeMask,
    output logic [NumEntries-1:0]      WriteEn,
    output rsPkg::entryT               NewEntry
);
    import rsPkg::*;

    operandT opA;
    operandT opB;
    logic    found;

    // Register file, then same-cycle CDB, then ROB forward, else wait on producer.
    function automatic operandT resolveSrc(input srcLookupT src, input cdbT bus);
        operandT res;
        res.pending = 1'b0;
        res.tag     = src.tag;
        res.value   = '0;
        if (!src.busy) begin
            res.value = src.rfData;
        end else if (bus.valid && (bus.tag == src.tag)) begin
            res.value = bus.value;  // Bypass.
        end else if (src.fwdValid) begin
            res.value = src.fwdData;
        end else begin
            res.pending = 1'b1;
        end
        return res;
    endfunction

    always_comb begin
        opA = resolveSrc(IssueReq.srcA, Cdb);
        opB = resolveSrc(IssueReq.srcB, Cdb);
        if (IssueReq.immSel) begin
            opB.pending = 1'b0;
            opB.tag     = '0;
            opB.value   = IssueReq.imm;
        end
    end

    always_comb begin
        NewEntry.op   = IssueReq.op;
        NewEntry.dest = IssueReq.dest;
        NewEntry.opA  = opA;
        NewEntry.opB  = opB;
    end

    // Lowest free entry wins.
    always_comb begin
        WriteEn = '0;
        found   = 1'b0;
        for (int i = 0; i < NumEntries; i++) begin
            if (FreeMask[i] && !found) begin
                WriteEn[i] = Issue;
                found      = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rsPkg.sv */
`default_nettype none

package rsPkg;

    localparam int DataWidth   = 32;
    localparam int RobTagWidth = 3;  // Eight instructions in flight.

    // ALU opcodes carried through the station.
    typedef enum logic [4:0] {
        Add = 5'd0,
        Sub = 5'd1,
        And = 5'd2,
        Orr = 5'd3,
        Eor = 5'd4,
        Mov = 5'd5
    } aluOpT;

    typedef enum logic [1:0] {
        Free       = 2'd0,
        Waiting    = 2'd1,
        Dispatched = 2'd2
    } entryStateT;

    // One resolved source operand.
    typedef struct packed {
        logic                   pending;
        logic [RobTagWidth-1:0] tag;
        logic [DataWidth-1:0]   value;
    } operandT;

    // Register status, ROB forward and register file data for one source.
    typedef struct packed {
        logic                   busy;
        logic [RobTagWidth-1:0] tag;  // Producer tag.
        logic                   fwdValid;
        logic [DataWidth-1:0]   fwdData;
        logic [DataWidth-1:0]   rfData;
    } srcLookupT;

    typedef struct packed {
        aluOpT                  op;
        logic [RobTagWidth-1:0] dest;
        logic                   immSel;  // Immediate replaces source B.
        logic [DataWidth-1:0]   imm;
        srcLookupT              srcA;
        srcLookupT              srcB;
    } issueReqT;

    typedef struct packed {
        logic                   valid;
        logic [RobTagWidth-1:0] tag;
        logic [DataWidth-1:0]   value;
    } cdbT;

    typedef struct packed {
        aluOpT                  op;
        logic [RobTagWidth-1:0] dest;
        logic [DataWidth-1:0]   srcA;
        logic [DataWidth-1:0]   srcB;
    } execReqT;

    typedef struct packed {
        aluOpT                  op;
        logic [RobTagWidth-1:0] dest;
        operandT                opA;
        operandT                opB;
    } entryT;

endpackage

`default_nettype wire
